//--- hqm_mem_trace.txt
1 0 R 000 00000000
1 1 R 3fc 00000000
2 0 W 010 fedcba98
2 1 W 023 12345678
3 1 R 010 000cba98
4 0 R 021 00045678
4 1 R 020 00045678
5 1 W 404 abcde123
6 0 R 004 000de123
6 1 R 806 000de123
7 0 W 100 0000aaaa
7 1 W 200 000bbbbb
8 0 R 200 000bbbbb
8 1 R 100 0000aaaa
9 0 W 3fc ffffffff
9 1 R 010 000cba98
10 0 R 3fc 000fffff
10 1 W 0f0 00012345
11 0 R 0f0 00012345
11 1 R 3ff 000fffff
12 0 W 048 00088888
12 1 W 044 00077777
13 0 R 044 00077777
13 1 R 048 00088888

//--- src.f
+incdir+.
hqm_mem_pkg.sv
hqm_rf_256x20.sv
hqm_rf_arbiter.sv
hqm_axil_rf_port.sv
hqm_mem_top.sv
tb_hqm_mem_top.sv

//--- Makefile
# Verilator build and run of the shared memory block testbench
# Any variable can be overridden, for example: make TOP=tb_hqm_mem_top LOG=run.log

VERILATOR  ?= verilator
TOP        ?= tb_hqm_mem_top
FILELIST   ?= src.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Verification passed
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert

SOURCES := $(wildcard *.sv *.svh) $(FILELIST)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "Run did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_hqm_mem_top.sv
// Testbench for the shared memory block
// Replays the operation trace on both AXI4-Lite ports and keeps a shadow copy of the
// register file to predict every read
// Trace lines that share a group number start on their ports in the same cycle

`timescale 1ns/1ns
`default_nettype none

`include "hqm_mem_defs.svh"

module tb_hqm_mem_top;

    localparam int MAX_LINES = 64;

    logic clk = 1'b0;
    logic arst_n;

    // Port signals, indexed by port number
    logic                     awvalid [2];
    logic                     awready [2];
    hqm_mem_pkg::axi_addr_t   awaddr  [2];
    logic                     wvalid  [2];
    logic                     wready  [2];
    hqm_mem_pkg::axi_data_t   wdata   [2];
    logic [`HQM_AXI_DW/8-1:0] wstrb   [2];
    logic                     bvalid  [2];
    logic                     bready  [2];
    logic [1:0]               bresp   [2];
    logic                     arvalid [2];
    logic                     arready [2];
    hqm_mem_pkg::axi_addr_t   araddr  [2];
    logic                     rvalid  [2];
    logic                     rready  [2];
    hqm_mem_pkg::axi_data_t   rdata   [2];
    logic [1:0]               rresp   [2];

    // Trace columns: group, port, R or W, byte address, write data or expected read data
    int          tr_grp  [MAX_LINES];
    int          tr_port [MAX_LINES];
    logic [7:0]  tr_op   [MAX_LINES];
    logic [31:0] tr_addr [MAX_LINES];
    logic [31:0] tr_data [MAX_LINES];
    int          n_lines;

    hqm_mem_pkg::rf_data_t shadow [`HQM_RF_DEPTH];
    int seed        = 94;
    int mismatches  = 0;
    int failures    = 0;
    int responses   = 0;
    int cycles      = 0;
    int cycle_limit = 30 * MAX_LINES + 200;

    always #20 clk = ~clk;

    hqm_mem_top uut (
         .clk        (clk)
        ,.arst_n     (arst_n)
        ,.p0_awvalid (awvalid[0])
        ,.p0_awready (awready[0])
        ,.p0_awaddr  (awaddr[0])
        ,.p0_wvalid  (wvalid[0])
        ,.p0_wready  (wready[0])
        ,.p0_wdata   (wdata[0])
        ,.p0_wstrb   (wstrb[0])
        ,.p0_bvalid  (bvalid[0])
        ,.p0_bready  (bready[0])
        ,.p0_bresp   (bresp[0])
        ,.p0_arvalid (arvalid[0])
        ,.p0_arready (arready[0])
        ,.p0_araddr  (araddr[0])
        ,.p0_rvalid  (rvalid[0])
        ,.p0_rready  (rready[0])
        ,.p0_rdata   (rdata[0])
        ,.p0_rresp   (rresp[0])
        ,.p1_awvalid (awvalid[1])
        ,.p1_awready (awready[1])
        ,.p1_awaddr  (awaddr[1])
        ,.p1_wvalid  (wvalid[1])
        ,.p1_wready  (wready[1])
        ,.p1_wdata   (wdata[1])
        ,.p1_wstrb   (wstrb[1])
        ,.p1_bvalid  (bvalid[1])
        ,.p1_bready  (bready[1])
        ,.p1_bresp   (bresp[1])
        ,.p1_arvalid (arvalid[1])
        ,.p1_arready (arready[1])
        ,.p1_araddr  (araddr[1])
        ,.p1_rvalid  (rvalid[1])
        ,.p1_rready  (rready[1])
        ,.p1_rdata   (rdata[1])
        ,.p1_rresp   (rresp[1])
    );

    // --------------------
    // Checks
    // --------------------

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            mismatches++;
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        failures++;
        $display("Error at %0t ns: %s", $time, what);
    endtask

    // The run ends here if a response never arrives
    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, a response never completed", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    // Responses the master actually accepted on either port
    // Valid and ready only change just after a rising edge, so the falling edge sees
    // the same values as the handshake edge that follows it
    always @(negedge clk) begin
        for (int m = 0; m < 2; m++) begin
            if (bvalid[m] === 1'b1 && bready[m] === 1'b1) begin
                responses++;
            end
            if (rvalid[m] === 1'b1 && rready[m] === 1'b1) begin
                responses++;
            end
        end
    end

    // --------------------
    // One trace line on one port
    // --------------------

    // Starts at 2 ns after a rising edge and returns at the same point of a later cycle
    // Ready signals are sampled on the falling edge, where they are settled
    task automatic run_op(input int p, input int k, input logic [31:0] expected,
                          input int stall);
        hqm_mem_pkg::axi_data_t first;
        if (tr_op[k] == "W") begin
            awaddr[p]  = tr_addr[k][`HQM_AXI_AW-1:0];
            wdata[p]   = tr_data[k];
            wstrb[p]   = '1;
            awvalid[p] = 1'b1;
            wvalid[p]  = 1'b1;
            do begin
                @(negedge clk);
            end while (!(awready[p] && wready[p]));
            @(posedge clk);
            #2;
            awvalid[p] = 1'b0;
            wvalid[p]  = 1'b0;
            do begin
                @(negedge clk);
            end while (!bvalid[p]);
            check_equal($sformatf("p%0d_bresp", p), {30'd0, bresp[p]}, 32'd0);
            // The master stalls with bready low and bvalid must hold
            repeat (stall) begin
                @(negedge clk);
                assert (bvalid[p]) else
                    report_failure($sformatf("p%0d_bvalid dropped before bready", p));
            end
            @(posedge clk);
            #2;
            bready[p] = 1'b1;
            @(posedge clk);
            #2;
            bready[p] = 1'b0;
        end else begin
            araddr[p]  = tr_addr[k][`HQM_AXI_AW-1:0];
            arvalid[p] = 1'b1;
            do begin
                @(negedge clk);
            end while (!arready[p]);
            @(posedge clk);
            #2;
            arvalid[p] = 1'b0;
            do begin
                @(negedge clk);
            end while (!rvalid[p]);
            first = rdata[p];
            check_equal($sformatf("p%0d_rdata", p), rdata[p], expected);
            check_equal($sformatf("p%0d_rdata (trace)", p), rdata[p], tr_data[k]);
            check_equal($sformatf("p%0d_rresp", p), {30'd0, rresp[p]}, 32'd0);
            // Data has to stay put while rready is low
            repeat (stall) begin
                @(negedge clk);
                assert (rvalid[p]) else
                    report_failure($sformatf("p%0d_rvalid dropped before rready", p));
                check_equal($sformatf("p%0d_rdata (held)", p), rdata[p], first);
            end
            @(posedge clk);
            #2;
            rready[p] = 1'b1;
            @(posedge clk);
            #2;
            rready[p] = 1'b0;
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------

    initial begin
        int          fd;
        int          g;
        int          pp;
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] d;
        int          i;
        int          j;
        int          q;
        int          idx     [2];
        int          stall_n [2];
        logic [31:0] exp_val [2];

        arst_n = 1'b0;
        for (q = 0; q < 2; q++) begin
            awvalid[q] = 1'b0;
            awaddr[q]  = '0;
            wvalid[q]  = 1'b0;
            wdata[q]   = '0;
            wstrb[q]   = '0;
            bready[q]  = 1'b0;
            arvalid[q] = 1'b0;
            araddr[q]  = '0;
            rready[q]  = 1'b0;
            exp_val[q] = '0;
            stall_n[q] = 0;
        end
        for (q = 0; q < `HQM_RF_DEPTH; q++) begin
            shadow[q] = '0;
        end

        n_lines = 0;
        fd = $fopen("hqm_mem_trace.txt", "r");
        if (fd == 0) begin
            report_failure("could not open the trace file hqm_mem_trace.txt");
        end else begin
            while (n_lines < MAX_LINES &&
                   $fscanf(fd, "%d %d %s %h %h\n", g, pp, op, a, d) == 5) begin
                tr_grp[n_lines]  = g;
                tr_port[n_lines] = pp;
                tr_op[n_lines]   = op;
                tr_addr[n_lines] = a;
                tr_data[n_lines] = d;
                n_lines++;
            end
            $fclose(fd);
        end
        cycle_limit = 30 * n_lines + 200;

        // Reset, then give the register file time to leave its reset-release stage
        repeat (10) @(posedge clk);
        #2;
        arst_n = 1'b1;
        repeat (3) @(posedge clk);
        #2;

        i = 0;
        while (i < n_lines) begin
            idx[0] = -1;
            idx[1] = -1;
            j = i;
            while (j < n_lines && tr_grp[j] == tr_grp[i]) begin
                if (tr_port[j] < 0 || tr_port[j] > 1 || idx[tr_port[j]] >= 0) begin
                    report_failure($sformatf("trace line %0d has a bad or repeated port", j + 1));
                end else begin
                    idx[tr_port[j]] = j;
                end
                j++;
            end
            // Reads in a group see the memory as it stood before that group's writes
            for (q = 0; q < 2; q++) begin
                if (idx[q] >= 0) begin
                    exp_val[q] = {{(`HQM_AXI_DW-`HQM_RF_DW){1'b0}},
                                  shadow[tr_addr[idx[q]][`HQM_AXI_AW-1:2]]};
                end
            end
            for (q = 0; q < 2; q++) begin
                if (idx[q] >= 0 && tr_op[idx[q]] == "W") begin
                    shadow[tr_addr[idx[q]][`HQM_AXI_AW-1:2]] = tr_data[idx[q]][`HQM_RF_DW-1:0];
                end
            end
            // Back-pressure lengths for this group, port 0 first
            for (q = 0; q < 2; q++) begin
                if (idx[q] >= 0) begin
                    stall_n[q] = $unsigned($random(seed)) % 4;
                end
            end
            fork
                begin
                    if (idx[0] >= 0) begin
                        run_op(0, idx[0], exp_val[0], stall_n[0]);
                    end
                end
                begin
                    if (idx[1] >= 0) begin
                        run_op(1, idx[1], exp_val[1], stall_n[1]);
                    end
                end
            join
            i = j;
        end

        // One response per trace line means nothing was dropped or taken twice
        assert (responses == n_lines) else
            report_failure($sformatf("%0d responses for %0d trace lines", responses, n_lines));
        if (n_lines == 0) begin
            report_failure("the trace holds no operations");
        end

        $display("Checks done: %0d mismatches, %0d other errors, %0d responses",
                 mismatches, failures, responses);
        if (mismatches == 0 && failures == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hqm_mem_top.sv
// Top level of the shared memory block: two AXI4-Lite peers share one
// 256x20 register file through a round-robin arbiter
// All ports run on clk and reset together on arst_n

`timescale 1ns/1ns
`default_nettype none

`include "hqm_mem_defs.svh"

module hqm_mem_top (
     input  logic                    clk
    ,input  logic                    arst_n

    // --------------------
    // Port 0
    ,input  logic                    p0_awvalid
    ,output logic                    p0_awready
    ,input  hqm_mem_pkg::axi_addr_t  p0_awaddr
    ,input  logic                    p0_wvalid
    ,output logic                    p0_wready
    ,input  hqm_mem_pkg::axi_data_t  p0_wdata
    ,input  logic [`HQM_AXI_DW/8-1:0] p0_wstrb
    ,output logic                    p0_bvalid
    ,input  logic                    p0_bready
    ,output logic [1:0]              p0_bresp
    ,input  logic                    p0_arvalid
    ,output logic                    p0_arready
    ,input  hqm_mem_pkg::axi_addr_t  p0_araddr
    ,output logic                    p0_rvalid
    ,input  logic                    p0_rready
    ,output hqm_mem_pkg::axi_data_t  p0_rdata
    ,output logic [1:0]              p0_rresp

    // --------------------
    // Port 1
    ,input  logic                    p1_awvalid
    ,output logic                    p1_awready
    ,input  hqm_mem_pkg::axi_addr_t  p1_awaddr
    ,input  logic                    p1_wvalid
    ,output logic                    p1_wready
    ,input  hqm_mem_pkg::axi_data_t  p1_wdata
    ,input  logic [`HQM_AXI_DW/8-1:0] p1_wstrb
    ,output logic                    p1_bvalid
    ,input  logic                    p1_bready
    ,output logic [1:0]              p1_bresp
    ,input  logic                    p1_arvalid
    ,output logic                    p1_arready
    ,input  hqm_mem_pkg::axi_addr_t  p1_araddr
    ,output logic                    p1_rvalid
    ,input  logic                    p1_rready
    ,output hqm_mem_pkg::axi_data_t  p1_rdata
    ,output logic [1:0]              p1_rresp
);

    // Port requests toward the arbiter
    logic                  req0;
    logic                  req1;
    logic                  req_we0;
    logic                  req_we1;
    hqm_mem_pkg::rf_addr_t req_addr0;
    hqm_mem_pkg::rf_addr_t req_addr1;
    hqm_mem_pkg::rf_data_t req_wdata0;
    hqm_mem_pkg::rf_data_t req_wdata1;
    logic                  gnt0;
    logic                  gnt1;

    // Arbitrated register-file controls, and read data shared by both ports
    logic                  rf_we;
    logic                  rf_re;
    hqm_mem_pkg::rf_addr_t rf_waddr;
    hqm_mem_pkg::rf_addr_t rf_raddr;
    hqm_mem_pkg::rf_data_t rf_wdata;
    hqm_mem_pkg::rf_data_t rf_rdata;

    hqm_axil_rf_port u_port0 (
         .clk       (clk)
        ,.arst_n    (arst_n)
        ,.awvalid   (p0_awvalid)
        ,.awready   (p0_awready)
        ,.awaddr    (p0_awaddr)
        ,.wvalid    (p0_wvalid)
        ,.wready    (p0_wready)
        ,.wdata     (p0_wdata)
        ,.wstrb     (p0_wstrb)
        ,.bvalid    (p0_bvalid)
        ,.bready    (p0_bready)
        ,.bresp     (p0_bresp)
        ,.arvalid   (p0_arvalid)
        ,.arready   (p0_arready)
        ,.araddr    (p0_araddr)
        ,.rvalid    (p0_rvalid)
        ,.rready    (p0_rready)
        ,.rdata     (p0_rdata)
        ,.rresp     (p0_rresp)
        ,.req       (req0)
        ,.req_we    (req_we0)
        ,.req_addr  (req_addr0)
        ,.req_wdata (req_wdata0)
        ,.gnt       (gnt0)
        ,.rf_rdata  (rf_rdata)
    );

    hqm_axil_rf_port u_port1 (
         .clk       (clk)
        ,.arst_n    (arst_n)
        ,.awvalid   (p1_awvalid)
        ,.awready   (p1_awready)
        ,.awaddr    (p1_awaddr)
        ,.wvalid    (p1_wvalid)
        ,.wready    (p1_wready)
        ,.wdata     (p1_wdata)
        ,.wstrb     (p1_wstrb)
        ,.bvalid    (p1_bvalid)
        ,.bready    (p1_bready)
        ,.bresp     (p1_bresp)
        ,.arvalid   (p1_arvalid)
        ,.arready   (p1_arready)
        ,.araddr    (p1_araddr)
        ,.rvalid    (p1_rvalid)
        ,.rready    (p1_rready)
        ,.rdata     (p1_rdata)
        ,.rresp     (p1_rresp)
        ,.req       (req1)
        ,.req_we    (req_we1)
        ,.req_addr  (req_addr1)
        ,.req_wdata (req_wdata1)
        ,.gnt       (gnt1)
        ,.rf_rdata  (rf_rdata)
    );

    hqm_rf_arbiter u_arb (
         .clk        (clk)
        ,.arst_n     (arst_n)
        ,.req0       (req0)
        ,.req_we0    (req_we0)
        ,.req_addr0  (req_addr0)
        ,.req_wdata0 (req_wdata0)
        ,.gnt0       (gnt0)
        ,.req1       (req1)
        ,.req_we1    (req_we1)
        ,.req_addr1  (req_addr1)
        ,.req_wdata1 (req_wdata1)
        ,.gnt1       (gnt1)
        ,.we         (rf_we)
        ,.waddr      (rf_waddr)
        ,.wdata      (rf_wdata)
        ,.re         (rf_re)
        ,.raddr      (rf_raddr)
    );

    hqm_rf_256x20 u_rf (
         .clk    (clk)
        ,.arst_n (arst_n)
        ,.we     (rf_we)
        ,.waddr  (rf_waddr)
        ,.wdata  (rf_wdata)
        ,.re     (rf_re)
        ,.raddr  (rf_raddr)
        ,.rdata  (rf_rdata)
    );

endmodule

`default_nettype wire

//--- hqm_axil_rf_port.sv
// AXI4-Lite slave port onto the shared register file
// Takes one transaction at a time, turns it into a single-word request to the
// arbiter, and holds the response until the master takes it
// Entry index comes from byte address bits 9 to 2; only the low 20 bits are stored

`timescale 1ns/1ns
`default_nettype none

`include "hqm_mem_defs.svh"

module hqm_axil_rf_port (
     input  logic                    clk
    ,input  logic                    arst_n

    ,input  logic                    awvalid
    ,output logic                    awready
    ,input  hqm_mem_pkg::axi_addr_t  awaddr

    ,input  logic                    wvalid
    ,output logic                    wready
    ,input  hqm_mem_pkg::axi_data_t  wdata
    ,input  logic [`HQM_AXI_DW/8-1:0] wstrb

    ,output logic                    bvalid
    ,input  logic                    bready
    ,output logic [1:0]              bresp

    ,input  logic                    arvalid
    ,output logic                    arready
    ,input  hqm_mem_pkg::axi_addr_t  araddr

    ,output logic                    rvalid
    ,input  logic                    rready
    ,output hqm_mem_pkg::axi_data_t  rdata
    ,output logic [1:0]              rresp

    ,output logic                    req
    ,output logic                    req_we
    ,output hqm_mem_pkg::rf_addr_t   req_addr
    ,output hqm_mem_pkg::rf_data_t   req_wdata
    ,input  logic                    gnt
    ,input  hqm_mem_pkg::rf_data_t   rf_rdata
);

    hqm_mem_pkg::port_state_t state_q;
    hqm_mem_pkg::rf_addr_t    addr_q;
    hqm_mem_pkg::rf_data_t    wdata_q;
    hqm_mem_pkg::rf_data_t    rdata_q;
    logic                     bvalid_q;
    logic                     rvalid_q;
    logic                     wr_accept;
    logic                     rd_accept;

    // --------------------
    // Address and data acceptance
    // --------------------

    // AW and W are taken together, and a write wins over a read pending alongside it
    assign wr_accept = (state_q == hqm_mem_pkg::IDLE) && awvalid && wvalid;
    assign rd_accept = (state_q == hqm_mem_pkg::IDLE) && arvalid && !(awvalid && wvalid);

    assign awready = wr_accept;
    assign wready  = wr_accept;
    assign arready = rd_accept;

    // --------------------
    // Transaction FSM
    // --------------------

    // B_RESP spends one cycle before bvalid, so writes answer with the same latency as reads
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q  <= hqm_mem_pkg::IDLE;
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            case (state_q)
                hqm_mem_pkg::IDLE: begin
                    if (wr_accept) begin
                        state_q <= hqm_mem_pkg::WR_REQ;
                    end else if (rd_accept) begin
                        state_q <= hqm_mem_pkg::RD_REQ;
                    end
                end
                hqm_mem_pkg::WR_REQ: begin
                    if (gnt) begin
                        state_q <= hqm_mem_pkg::B_RESP;
                    end
                end
                hqm_mem_pkg::RD_REQ: begin
                    if (gnt) begin
                        state_q <= hqm_mem_pkg::RD_WAIT;
                    end
                end
                hqm_mem_pkg::RD_WAIT: begin
                    state_q  <= hqm_mem_pkg::R_RESP;
                    rvalid_q <= 1'b1;
                end
                hqm_mem_pkg::B_RESP: begin
                    if (!bvalid_q) begin
                        bvalid_q <= 1'b1;
                    end else if (bready) begin
                        bvalid_q <= 1'b0;
                        state_q  <= hqm_mem_pkg::IDLE;
                    end
                end
                hqm_mem_pkg::R_RESP: begin
                    if (rready) begin
                        rvalid_q <= 1'b0;
                        state_q  <= hqm_mem_pkg::IDLE;
                    end
                end
                default: begin
                    state_q <= hqm_mem_pkg::IDLE;
                end
            endcase
        end
    end

    // Payload captured on acceptance; read data taken the cycle after the read grant
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            addr_q  <= awaddr[`HQM_AXI_AW-1:2];
            wdata_q <= wdata[`HQM_RF_DW-1:0];
        end else if (rd_accept) begin
            addr_q  <= araddr[`HQM_AXI_AW-1:2];
        end
        if (state_q == hqm_mem_pkg::RD_WAIT) begin
            rdata_q <= rf_rdata;
        end
    end

    // --------------------
    // Outputs
    // --------------------

    // Request stays up until the grant cycle, which is when the access happens
    assign req       = (state_q == hqm_mem_pkg::WR_REQ) || (state_q == hqm_mem_pkg::RD_REQ);
    assign req_we    = (state_q == hqm_mem_pkg::WR_REQ);
    assign req_addr  = addr_q;
    assign req_wdata = wdata_q;

    assign bvalid = bvalid_q;
    assign rvalid = rvalid_q;
    assign rdata  = {{(`HQM_AXI_DW-`HQM_RF_DW){1'b0}}, rdata_q};
    // Always OKAY
    assign bresp  = 2'b00;
    assign rresp  = 2'b00;

    // Full-word writes only; the strobes must cover the three bytes that hold the stored bits
    a_wstrb_full: assert property (@(posedge clk) disable iff (!arst_n)
        (wvalid && wready) |-> (wstrb[2:0] == 3'b111));

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (bvalid && !bready) |=> bvalid);

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (rvalid && !rready) |=> (rvalid && $stable(rdata)));

endmodule

`default_nettype wire

//--- hqm_rf_arbiter.sv
// Round-robin arbiter between the two AXI4-Lite ports and the register file
// One request wins per cycle; the winner's request drives the array controls
// in the same cycle, and the pointer moves after every grant

`timescale 1ns/1ns
`default_nettype none

module hqm_rf_arbiter (
     input  logic                  clk
    ,input  logic                  arst_n

    ,input  logic                  req0
    ,input  logic                  req_we0
    ,input  hqm_mem_pkg::rf_addr_t req_addr0
    ,input  hqm_mem_pkg::rf_data_t req_wdata0
    ,output logic                  gnt0

    ,input  logic                  req1
    ,input  logic                  req_we1
    ,input  hqm_mem_pkg::rf_addr_t req_addr1
    ,input  hqm_mem_pkg::rf_data_t req_wdata1
    ,output logic                  gnt1

    ,output logic                  we
    ,output hqm_mem_pkg::rf_addr_t waddr
    ,output hqm_mem_pkg::rf_data_t wdata
    ,output logic                  re
    ,output hqm_mem_pkg::rf_addr_t raddr
);

    // High when port 1 won last, so port 0 has priority next time
    logic last1_q;

    // --------------------
    // Grant
    // --------------------

    // A lone request always wins; on a tie the port that did not win last goes
    assign gnt0 = req0 && (!req1 || last1_q);
    assign gnt1 = req1 && (!req0 || !last1_q);

    // Reset value makes port 0 the favored side on the first tie
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last1_q <= 1'b1;
        end else if (gnt0) begin
            last1_q <= 1'b0;
        end else if (gnt1) begin
            last1_q <= 1'b1;
        end
    end

    // --------------------
    // Steering
    // --------------------

    assign we    = (gnt0 && req_we0) || (gnt1 && req_we1);
    assign re    = (gnt0 && !req_we0) || (gnt1 && !req_we1);
    assign waddr = gnt1 ? req_addr1 : req_addr0;
    assign raddr = gnt1 ? req_addr1 : req_addr0;
    assign wdata = gnt1 ? req_wdata1 : req_wdata0;

    a_gnt_onehot: assert property (@(posedge clk) disable iff (!arst_n) !(gnt0 && gnt1));

    a_gnt_has_req: assert property (@(posedge clk) disable iff (!arst_n)
        (gnt0 |-> req0) and (gnt1 |-> req1));

    // Ports hold a losing request, so the loser is served in the very next cycle
    a_no_starve: assert property (@(posedge clk) disable iff (!arst_n)
        (req0 && !gnt0) |=> gnt0);

endmodule

`default_nettype wire

//--- hqm_rf_256x20.sv
// Behavioral model of the 256x20 two-port register file
// Write lands on the clock edge with we high; read data is registered on re
// and appears the cycle after the read request

`timescale 1ns/1ns
`default_nettype none

`include "hqm_mem_defs.svh"

module hqm_rf_256x20 (
     input  logic                  clk
    ,input  logic                  arst_n
    ,input  logic                  we
    ,input  hqm_mem_pkg::rf_addr_t waddr
    ,input  hqm_mem_pkg::rf_data_t wdata
    ,input  logic                  re
    ,input  hqm_mem_pkg::rf_addr_t raddr
    ,output hqm_mem_pkg::rf_data_t rdata
);

    hqm_mem_pkg::rf_data_t mem [`HQM_RF_DEPTH];
    hqm_mem_pkg::rf_data_t rdata_q;
    logic [1:0]            rst_sync_q;
    logic                  rst_rel;

    // --------------------
    // Reset release
    // --------------------

    // Reset asserts at once and releases two clocks after arst_n rises
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rst_sync_q <= 2'b00;
        end else begin
            rst_sync_q <= {rst_sync_q[0], 1'b1};
        end
    end

    assign rst_rel = rst_sync_q[1];

    // --------------------
    // Array and read port
    // --------------------

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Output holds zero until the first read after the release
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdata_q <= '0;
        end else if (!rst_rel) begin
            rdata_q <= '0;
        end else if (re) begin
            rdata_q <= mem[raddr];
        end
    end

    assign rdata = rdata_q;

    // The arbiter hands the array to one port per cycle, so no access mixes both sides
    a_no_we_re: assert property (@(posedge clk) disable iff (!arst_n) !(we && re));

endmodule

`default_nettype wire

//--- hqm_mem_pkg.sv
// Shared types for the queue-manager shared memory block
// Modules refer to these by scoped name, hqm_mem_pkg::<type>

`default_nettype none

`include "hqm_mem_defs.svh"

package hqm_mem_pkg;

    // Register-file entry index and stored word
    typedef logic [`HQM_RF_AW-1:0]  rf_addr_t;
    typedef logic [`HQM_RF_DW-1:0]  rf_data_t;

    // AXI4-Lite byte address and bus word
    typedef logic [`HQM_AXI_AW-1:0] axi_addr_t;
    typedef logic [`HQM_AXI_DW-1:0] axi_data_t;

    // One transaction in flight per port, from acceptance to response
    typedef enum logic [2:0] {
        IDLE, WR_REQ, RD_REQ, RD_WAIT, B_RESP, R_RESP
    } port_state_t;

endpackage

`default_nettype wire

//--- hqm_mem_defs.svh
// Geometry of the shared register file and widths of the AXI4-Lite ports
// Include this wherever a width is needed; the package builds its types on it
// The register file is a fixed 256x20 part, so none of these are overridden

`ifndef HQM_MEM_DEFS_SVH
`define HQM_MEM_DEFS_SVH

// --------------------
// Register file
// --------------------

`define HQM_RF_DEPTH 256
`define HQM_RF_AW    8
`define HQM_RF_DW    20

// --------------------
// AXI4-Lite slave ports
// --------------------

// 1 KB byte window, so an entry index sits in bits 9 to 2
`define HQM_AXI_AW   10
`define HQM_AXI_DW   32

`endif
